// ==== project.f ====
hw/wasm_pkg.sv
hw/program_memory.sv
hw/leb128_decoder.sv
hw/operand_stack.sv
hw/wasm_alu.sv
hw/wasm_exec.sv
hw/wasm_cpu.sv
+incdir+verif
verif/tb_wasm_cpu.sv

// ==== Makefile ====
# Verilator build and run for the stack processor testbench

SIM := obj_dir/Vtb_wasm_cpu

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): project.f hw/*.sv verif/*.sv verif/*.svh
	verilator --binary --timing --assert -Wno-fatal --top-module tb_wasm_cpu \
	  -Mdir obj_dir -f project.f

# The log decides pass or fail
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Each row gives program bytes (first byte leftmost), byte count,
// expected trap, expected top entry type and value, expected empty flag
task automatic build_program_table();
  // Single and multi-byte LEB128 constants of both signs
  add_program(24'h41_7f_0b, 3, TRAP_ENDED, I32, 64'hffff_ffff, 1'b0);
  add_program(40'h41_e5_8e_26_0b, 5, TRAP_ENDED, I32, 64'h9_8765, 1'b0);
  add_program(40'h42_c0_bb_78_0b, 5, TRAP_ENDED, I64, 64'hffff_ffff_fffe_1dc0, 1'b0);
  add_program(56'h42_80_80_80_80_10_0b, 7, TRAP_ENDED, I64, 64'h1_0000_0000, 1'b0);

  // Sub takes the second operand minus the top
  add_program(48'h41_7f_41_02_6a_0b, 6, TRAP_ENDED, I32, 64'h1, 1'b0);
  add_program(48'h41_05_41_07_6b_0b, 6, TRAP_ENDED, I32, 64'hffff_fffe, 1'b0);
  add_program(80'h41_80_80_80_80_78_41_01_6b_0b, 10,
              TRAP_ENDED, I32, 64'h7fff_ffff, 1'b0);
  add_program(96'h42_80_80_80_80_10_42_c0_bb_78_7c_0b, 12,
              TRAP_ENDED, I64, 64'hfffe_1dc0, 1'b0);
  add_program(48'h42_7f_42_01_7c_0b, 6, TRAP_ENDED, I64, 64'h0, 1'b0);
  add_program(48'h42_00_42_01_7d_0b, 6, TRAP_ENDED, I64, 64'hffff_ffff_ffff_ffff, 1'b0);

  // Comparisons always give an I32 flag
  add_program(48'h41_05_41_05_46_0b, 6, TRAP_ENDED, I32, 64'h1, 1'b0);
  add_program(48'h41_05_41_06_46_0b, 6, TRAP_ENDED, I32, 64'h0, 1'b0);
  add_program(48'h41_03_41_03_47_0b, 6, TRAP_ENDED, I32, 64'h0, 1'b0);
  add_program(48'h42_01_42_02_51_0b, 6, TRAP_ENDED, I32, 64'h0, 1'b0);
  add_program(48'h42_00_42_7f_52_0b, 6, TRAP_ENDED, I32, 64'h1, 1'b0);
  add_program(32'h41_00_45_0b, 4, TRAP_ENDED, I32, 64'h1, 1'b0);
  // Low half is zero, so only a full 64-bit test gives 0
  add_program(64'h42_80_80_80_80_10_50_0b, 8, TRAP_ENDED, I32, 64'h0, 1'b0);

  // Parametric instructions
  add_program(40'h01_41_09_01_0b, 5, TRAP_ENDED, I32, 64'h9, 1'b0);
  add_program(64'h41_0a_41_14_41_01_1b_0b, 8, TRAP_ENDED, I32, 64'ha, 1'b0);
  add_program(64'h41_0a_41_14_41_00_1b_0b, 8, TRAP_ENDED, I32, 64'h14, 1'b0);
  add_program(64'h42_0a_42_14_41_01_1b_0b, 8, TRAP_ENDED, I64, 64'ha, 1'b0);
  add_program(48'h41_05_41_06_1a_0b, 6, TRAP_ENDED, I32, 64'h5, 1'b0);
  add_program(32'h41_05_1a_0b, 4, TRAP_ENDED, I32, 64'h0, 1'b1);
  add_program(8'h0b, 1, TRAP_ENDED, I32, 64'h0, 1'b1);

  // Traps leave the previous top in place
  add_program(32'h41_2a_00_0b, 4, TRAP_UNREACHABLE, I32, 64'h2a, 1'b0);
  add_program(24'h41_2a_ff, 3, TRAP_UNKNOWN_OPCODE, I32, 64'h2a, 1'b0);
  add_program(40'h41_03_42_04_6a, 5, TRAP_TYPE_MISMATCH, I64, 64'h4, 1'b0);
  add_program(24'h41_05_6a, 3, TRAP_STACK_EMPTY, I32, 64'h5, 1'b0);
endtask

`endif

// ==== verif/tb_wasm_cpu.sv ====
`timescale 1ns/1ps

module tb_wasm_cpu;
  import wasm_pkg::*;

  localparam int ROM_ADDR_W    = 8;
  localparam int STACK_DEPTH_W = 4;
  localparam int MEM_SIZE      = 2 ** ROM_ADDR_W;
  localparam int MAX_LEN       = 24;
  localparam int RESET_CYCLES  = 10;
  // Loading, up to 24 instructions at 3 cycles, slack
  localparam int TEST_CYCLES   = 60 + 3 * 24 + 20;

  typedef struct packed {
    logic [8*MAX_LEN-1:0] code;
    logic [4:0]           len;
    trap_e                trap;
    stack_entry_t         result;
    logic                 empty;
  } program_case_t;

  logic                  clk;
  logic                  reset;
  logic                  load_en;
  logic [ROM_ADDR_W-1:0] load_addr;
  logic [7:0]            load_data;
  logic                  start;
  stack_entry_t          result;
  logic                  result_empty;
  trap_e                 trap;
  logic                  busy;

  program_case_t cases[$];
  int            cycles;
  int            cycle_limit;
  int            current_test;
  int            errors;
  int            test_errors;
  int            failed_tests;

  wasm_cpu #(
    .ROM_ADDR_W    (ROM_ADDR_W),
    .STACK_DEPTH_W (STACK_DEPTH_W)
  ) u_wasm_cpu (
    .clk          (clk),
    .reset        (reset),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .start        (start),
    .result       (result),
    .result_empty (result_empty),
    .trap         (trap),
    .busy         (busy)
  );

  task automatic add_program(input logic [8*MAX_LEN-1:0] code, input int len,
                             input trap_e exp_trap, input value_type_e exp_type,
                             input logic [63:0] exp_value, input logic exp_empty);
    program_case_t tc;
    tc.code         = code;
    tc.len          = 5'(len);
    tc.trap         = exp_trap;
    tc.result.vtype = exp_type;
    tc.result.value = exp_value;
    tc.empty        = exp_empty;
    cases.push_back(tc);
  endtask

  `include "tb_programs.svh"

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Run limit covers reset, the memory fill and every test
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: test %0d did not finish within %0d cycles", current_test, cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic write_byte(input int addr, input logic [7:0] data);
    @(posedge clk);
    load_en   <= 1'b1;
    load_addr <= ROM_ADDR_W'(addr);
    load_data <= data;
  endtask

  // Random background so that stray fetches would show
  task automatic fill_memory();
    for (int a = 0; a < MEM_SIZE; a++) begin
      write_byte(a, 8'($urandom));
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  task automatic load_program(input program_case_t tc);
    int n;
    n = int'(tc.len);
    for (int i = 0; i < n; i++) begin
      write_byte(i, tc.code[(n - 1 - i) * 8 +: 8]);
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  // Start pulse, then busy is sampled on falling edges
  task automatic run_program();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    while (busy) @(negedge clk);
  endtask

  task automatic check_idle_after_reset();
    assert (!busy && trap == TRAP_NONE && result_empty) else begin
      $display("[FAIL] %0t: after reset busy=%0b trap=%s empty=%0b",
               $time, busy, trap.name(), result_empty);
      errors++;
    end
  endtask

  task automatic check_outcome(input program_case_t tc, input int run);
    trap_e exp_trap;
    exp_trap = tc.trap;
    assert (trap == exp_trap) else begin
      $display("[FAIL] %0t: test %0d run %0d trap %s, expected %s",
               $time, current_test, run, trap.name(), exp_trap.name());
      test_errors++;
    end
    assert (result == tc.result) else begin
      $display("[FAIL] %0t: test %0d run %0d result type %0d value %h, expected %0d %h",
               $time, current_test, run, result.vtype, result.value,
               tc.result.vtype, tc.result.value);
      test_errors++;
    end
    assert (result_empty == tc.empty) else begin
      $display("[FAIL] %0t: test %0d run %0d result_empty %0b, expected %0b",
               $time, current_test, run, result_empty, tc.empty);
      test_errors++;
    end
  endtask

  initial begin
    reset        = 1'b1;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    start        = 1'b0;
    cycles       = 0;
    cycle_limit  = 0;
    current_test = 0;
    errors       = 0;
    test_errors  = 0;
    failed_tests = 0;
    void'($urandom(32'hf4d6));
    build_program_table();
    cycle_limit = RESET_CYCLES + MEM_SIZE + 4 + cases.size() * TEST_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_idle_after_reset();
    fill_memory();

    // Second run checks that start clears the stack and restarts at 0
    foreach (cases[t]) begin
      current_test = t;
      test_errors  = 0;
      load_program(cases[t]);
      for (int run = 0; run < 2; run++) begin
        run_program();
        check_outcome(cases[t], run);
      end
      if (test_errors == 0) begin
        $display("Test %0d: ok", t);
      end else begin
        $display("Test %0d: %0d mismatches", t, test_errors);
        failed_tests++;
      end
      errors += test_errors;
    end

    $display("Tests: %0d run, %0d passed, %0d failed, %0d check errors",
             cases.size(), cases.size() - failed_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== hw/wasm_cpu.sv ====
`timescale 1ns/1ps

module wasm_cpu #(
  parameter int ROM_ADDR_W    = 8,
  parameter int STACK_DEPTH_W = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   load_en,
  input  logic [ROM_ADDR_W-1:0]  load_addr,
  input  logic [7:0]             load_data,
  input  logic                   start,
  output wasm_pkg::stack_entry_t result,
  output logic                   result_empty,
  output wasm_pkg::trap_e        trap,
  output logic                   busy
);
  import wasm_pkg::*;

  logic [FETCH_BYTES-1:0][7:0] window;
  logic [ROM_ADDR_W-1:0]       fetch_addr;
  logic [63:0]                 imm_value;
  logic [3:0]                  imm_length;
  opcode_e                     opcode;
  stack_op_e                   stack_op;
  stack_entry_t                stack_wdata;
  stack_entry_t                alu_result;
  logic                        type_error;
  stack_entry_t                tos;
  stack_entry_t                nos;
  stack_entry_t                third;
  logic [STACK_DEPTH_W:0]      depth;

  // Input side
  program_memory #(
    .ROM_ADDR_W(ROM_ADDR_W)
  ) u_program_memory (
    .clk        (clk),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .fetch_addr (fetch_addr),
    .window     (window)
  );

  leb128_decoder u_leb128_decoder (
    .bytes  (window[10:1]),
    .value  (imm_value),
    .length (imm_length)
  );

  // Processing
  wasm_exec #(
    .ROM_ADDR_W    (ROM_ADDR_W),
    .STACK_DEPTH_W (STACK_DEPTH_W)
  ) u_wasm_exec (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .window      (window),
    .imm_value   (imm_value),
    .imm_length  (imm_length),
    .depth       (depth),
    .type_error  (type_error),
    .alu_result  (alu_result),
    .fetch_addr  (fetch_addr),
    .opcode      (opcode),
    .stack_op    (stack_op),
    .stack_wdata (stack_wdata),
    .trap        (trap),
    .busy        (busy)
  );

  wasm_alu u_wasm_alu (
    .opcode     (opcode),
    .tos        (tos),
    .nos        (nos),
    .third      (third),
    .alu_result (alu_result),
    .type_error (type_error)
  );

  // Output side
  operand_stack #(
    .STACK_DEPTH_W(STACK_DEPTH_W)
  ) u_operand_stack (
    .clk         (clk),
    .reset       (reset),
    .stack_op    (stack_op),
    .stack_wdata (stack_wdata),
    .tos         (tos),
    .nos         (nos),
    .third       (third),
    .depth       (depth)
  );

  assign result       = tos;
  assign result_empty = (depth == '0);

endmodule

// ==== hw/wasm_exec.sv ====
`timescale 1ns/1ps

module wasm_exec #(
  parameter int ROM_ADDR_W    = 8,
  parameter int STACK_DEPTH_W = 4
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  start,
  input  logic [wasm_pkg::FETCH_BYTES-1:0][7:0] window,
  input  logic [63:0]                           imm_value,
  input  logic [3:0]                            imm_length,
  input  logic [STACK_DEPTH_W:0]                depth,
  input  logic                                  type_error,
  input  wasm_pkg::stack_entry_t                alu_result,
  output logic [ROM_ADDR_W-1:0]                 fetch_addr,
  output wasm_pkg::opcode_e                     opcode,
  output wasm_pkg::stack_op_e                   stack_op,
  output wasm_pkg::stack_entry_t                stack_wdata,
  output wasm_pkg::trap_e                       trap,
  output logic                                  busy
);
  import wasm_pkg::*;

  localparam int DW = STACK_DEPTH_W + 1;

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    WAIT,
    EXEC
  } state_e;

  state_e                  state;
  logic [ROM_ADDR_W-1:0]   pc;
  logic [ROM_ADDR_W-1:0]   pc_next;
  logic                    known;
  logic                    is_push;
  logic                    check_type;
  logic [STACK_DEPTH_W:0]  need;
  trap_e                   halt_code;
  trap_e                   exec_trap;
  stack_op_e               exec_op;

  assign opcode = opcode_e'(window[0]);
  assign busy   = (state != IDLE);

  // Constants skip their immediate bytes too
  assign pc_next = pc + ROM_ADDR_W'(is_push ? imm_length + 4'd1 : 4'd1);

  // Decode
  always_comb begin
    known       = 1'b1;
    is_push     = 1'b0;
    check_type  = 1'b0;
    need        = '0;
    halt_code   = TRAP_NONE;
    exec_op     = SOP_NONE;
    stack_wdata = alu_result;
    case (opcode)
      OP_UNREACHABLE: halt_code = TRAP_UNREACHABLE;
      OP_NOP:         exec_op   = SOP_NONE;
      // No blocks, so end closes the program
      OP_END:         halt_code = TRAP_ENDED;
      OP_DROP: begin
        need    = DW'(1);
        exec_op = SOP_POP;
      end
      OP_SELECT: begin
        need       = DW'(3);
        check_type = 1'b1;
        exec_op    = SOP_POP2_REPLACE;
      end
      OP_I32_CONST: begin
        is_push           = 1'b1;
        exec_op           = SOP_PUSH;
        stack_wdata.vtype = I32;
        stack_wdata.value = {32'b0, imm_value[31:0]};
      end
      OP_I64_CONST: begin
        is_push           = 1'b1;
        exec_op           = SOP_PUSH;
        stack_wdata.vtype = I64;
        stack_wdata.value = imm_value;
      end
      OP_I32_EQZ, OP_I64_EQZ: begin
        need       = DW'(1);
        check_type = 1'b1;
        exec_op    = SOP_REPLACE;
      end
      OP_I32_EQ, OP_I32_NE, OP_I64_EQ, OP_I64_NE,
      OP_I32_ADD, OP_I32_SUB, OP_I64_ADD, OP_I64_SUB: begin
        need       = DW'(2);
        check_type = 1'b1;
        exec_op    = SOP_POP_REPLACE;
      end
      default: known = 1'b0;
    endcase
  end

  // Trap priority
  always_comb begin
    if (!known) begin
      exec_trap = TRAP_UNKNOWN_OPCODE;
    end else if (depth < need) begin
      exec_trap = TRAP_STACK_EMPTY;
    end else if (is_push && depth == DW'(2 ** STACK_DEPTH_W)) begin
      exec_trap = TRAP_STACK_FULL;
    end else if (check_type && type_error) begin
      exec_trap = TRAP_TYPE_MISMATCH;
    end else begin
      exec_trap = halt_code;
    end
  end

  // Stack update lands on the edge leaving EXEC
  always_comb begin
    stack_op = SOP_NONE;
    if (state == IDLE && start) begin
      stack_op = SOP_CLEAR;
    end else if (state == EXEC && exec_trap == TRAP_NONE) begin
      stack_op = exec_op;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      pc         <= '0;
      fetch_addr <= '0;
      trap       <= TRAP_NONE;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= FETCH;
            pc    <= '0;
            trap  <= TRAP_NONE;
          end
        end
        FETCH: begin
          fetch_addr <= pc;
          state      <= WAIT;
        end
        // Memory registers the window
        WAIT: state <= EXEC;
        EXEC: begin
          if (exec_trap != TRAP_NONE) begin
            trap  <= exec_trap;
            state <= IDLE;
          end else begin
            pc    <= pc_next;
            state <= FETCH;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// ==== hw/wasm_alu.sv ====
`timescale 1ns/1ps

module wasm_alu (
  input  wasm_pkg::opcode_e      opcode,
  input  wasm_pkg::stack_entry_t tos,
  input  wasm_pkg::stack_entry_t nos,
  input  wasm_pkg::stack_entry_t third,
  output wasm_pkg::stack_entry_t alu_result,
  output logic                   type_error
);
  import wasm_pkg::*;

  always_comb begin
    logic i32_pair;
    logic i64_pair;

    i32_pair   = (nos.vtype == I32) && (tos.vtype == I32);
    i64_pair   = (nos.vtype == I64) && (tos.vtype == I64);
    alu_result = '0;
    type_error = 1'b0;

    case (opcode)
      OP_I32_EQZ: begin
        type_error       = tos.vtype != I32;
        alu_result.value = {63'b0, tos.value[31:0] == 32'b0};
      end
      OP_I64_EQZ: begin
        type_error       = tos.vtype != I64;
        alu_result.value = {63'b0, tos.value == 64'b0};
      end
      // ne is eq inverted
      OP_I32_EQ, OP_I32_NE: begin
        type_error       = !i32_pair;
        alu_result.value = {63'b0, (nos.value[31:0] == tos.value[31:0]) ^
                                   (opcode == OP_I32_NE)};
      end
      OP_I64_EQ, OP_I64_NE: begin
        type_error       = !i64_pair;
        alu_result.value = {63'b0, (nos.value == tos.value) ^ (opcode == OP_I64_NE)};
      end
      OP_I32_ADD, OP_I32_SUB: begin
        type_error       = !i32_pair;
        alu_result.value = (opcode == OP_I32_ADD) ?
                           {32'b0, nos.value[31:0] + tos.value[31:0]} :
                           {32'b0, nos.value[31:0] - tos.value[31:0]};
      end
      OP_I64_ADD, OP_I64_SUB: begin
        type_error       = !i64_pair;
        alu_result.vtype = I64;
        alu_result.value = (opcode == OP_I64_ADD) ? nos.value + tos.value :
                                                    nos.value - tos.value;
      end
      // Deeper operand wins when the condition on top is non-zero
      OP_SELECT: begin
        type_error = (tos.vtype != I32) || (nos.vtype != third.vtype);
        alu_result = (tos.value[31:0] != 32'b0) ? third : nos;
      end
      default: begin
        alu_result = '0;
      end
    endcase
  end

endmodule

// ==== hw/operand_stack.sv ====
`timescale 1ns/1ps

module operand_stack #(
  parameter int STACK_DEPTH_W = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  wasm_pkg::stack_op_e    stack_op,
  input  wasm_pkg::stack_entry_t stack_wdata,
  output wasm_pkg::stack_entry_t tos,
  output wasm_pkg::stack_entry_t nos,
  output wasm_pkg::stack_entry_t third,
  output logic [STACK_DEPTH_W:0] depth
);
  import wasm_pkg::*;

  localparam int ENTRIES = 2 ** STACK_DEPTH_W;
  localparam int DW      = STACK_DEPTH_W + 1;

  stack_entry_t             entries [ENTRIES];
  logic [STACK_DEPTH_W-1:0] top_idx;
  logic [STACK_DEPTH_W-1:0] wr_idx;
  logic                     wr_en;

  // Wraps to the last slot when the stack is full
  assign top_idx = depth[STACK_DEPTH_W-1:0] - STACK_DEPTH_W'(1);

  // Slots above the depth read as zero
  assign tos   = (depth > DW'(0)) ? entries[top_idx] : '0;
  assign nos   = (depth > DW'(1)) ? entries[top_idx - STACK_DEPTH_W'(1)] : '0;
  assign third = (depth > DW'(2)) ? entries[top_idx - STACK_DEPTH_W'(2)] : '0;

  always_comb begin
    wr_en = 1'b1;
    case (stack_op)
      SOP_PUSH:         wr_idx = depth[STACK_DEPTH_W-1:0];
      SOP_REPLACE:      wr_idx = top_idx;
      SOP_POP_REPLACE:  wr_idx = top_idx - STACK_DEPTH_W'(1);
      SOP_POP2_REPLACE: wr_idx = top_idx - STACK_DEPTH_W'(2);
      default: begin
        wr_en  = 1'b0;
        wr_idx = top_idx;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      entries[wr_idx] <= stack_wdata;
    end
  end

  // Executor guarantees no underflow or overflow
  always_ff @(posedge clk) begin
    if (reset) begin
      depth <= '0;
    end else begin
      case (stack_op)
        SOP_PUSH:                  depth <= depth + DW'(1);
        SOP_POP, SOP_POP_REPLACE:  depth <= depth - DW'(1);
        SOP_POP2_REPLACE:          depth <= depth - DW'(2);
        SOP_CLEAR:                 depth <= '0;
        default:                   depth <= depth;
      endcase
    end
  end

endmodule

// ==== hw/leb128_decoder.sv ====
`timescale 1ns/1ps

module leb128_decoder (
  input  logic [9:0][7:0] bytes,
  output logic [63:0]     value,
  output logic [3:0]      length
);

  always_comb begin
    logic [69:0] groups;
    logic        done;
    int          last;

    groups = '0;
    done   = 1'b0;
    last   = 9;

    // Collect 7-bit groups up to the first byte without continuation
    for (int i = 0; i < 10; i++) begin
      if (!done) begin
        groups[i*7 +: 7] = bytes[i][6:0];
        if (!bytes[i][7]) begin
          done = 1'b1;
          last = i;
        end
      end
    end

    value = groups[63:0];

    // Sign extend from bit 6 of the final group
    for (int b = 0; b < 64; b++) begin
      if (b > last * 7 + 6 && groups[last*7+6]) begin
        value[b] = 1'b1;
      end
    end

    length = 4'(last + 1);
  end

endmodule

// ==== hw/program_memory.sv ====
`timescale 1ns/1ps

module program_memory #(
  parameter int ROM_ADDR_W = 8
) (
  input  logic                                   clk,
  input  logic                                   load_en,
  input  logic [ROM_ADDR_W-1:0]                  load_addr,
  input  logic [7:0]                             load_data,
  input  logic [ROM_ADDR_W-1:0]                  fetch_addr,
  output logic [wasm_pkg::FETCH_BYTES-1:0][7:0]  window
);
  import wasm_pkg::*;

  localparam int MEM_SIZE = 2 ** ROM_ADDR_W;

  logic [7:0] mem [MEM_SIZE];

  // Host load port
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // Byte 0 is the opcode, the rest feed the immediate decoder.
  // The index is self-determined so the address wraps at MEM_SIZE
  always_ff @(posedge clk) begin
    for (int i = 0; i < FETCH_BYTES; i++) begin
      window[i] <= mem[fetch_addr + ROM_ADDR_W'(i)];
    end
  end

endmodule

// ==== hw/wasm_pkg.sv ====
package wasm_pkg;

  // Opcode byte plus up to ten LEB128 immediate bytes
  localparam int FETCH_BYTES = 11;

  typedef enum logic [1:0] {
    I32 = 2'd0,
    I64 = 2'd1,
    F32 = 2'd2,
    F64 = 2'd3
  } value_type_e;

  // WebAssembly binary encodings
  typedef enum logic [7:0] {
    OP_UNREACHABLE = 8'h00,
    OP_NOP         = 8'h01,
    OP_END         = 8'h0B,
    OP_DROP        = 8'h1A,
    OP_SELECT      = 8'h1B,
    OP_I32_CONST   = 8'h41,
    OP_I64_CONST   = 8'h42,
    OP_I32_EQZ     = 8'h45,
    OP_I32_EQ      = 8'h46,
    OP_I32_NE      = 8'h47,
    OP_I64_EQZ     = 8'h50,
    OP_I64_EQ      = 8'h51,
    OP_I64_NE      = 8'h52,
    OP_I32_ADD     = 8'h6A,
    OP_I32_SUB     = 8'h6B,
    OP_I64_ADD     = 8'h7C,
    OP_I64_SUB     = 8'h7D
  } opcode_e;

  typedef enum logic [3:0] {
    TRAP_NONE,
    TRAP_ENDED,
    TRAP_UNREACHABLE,
    TRAP_TYPE_MISMATCH,
    TRAP_STACK_EMPTY,
    TRAP_STACK_FULL,
    TRAP_UNKNOWN_OPCODE
  } trap_e;

  typedef enum logic [2:0] {
    SOP_NONE,
    SOP_PUSH,
    SOP_POP,
    SOP_REPLACE,
    SOP_POP_REPLACE,
    SOP_POP2_REPLACE,
    SOP_CLEAR
  } stack_op_e;

  // I32 entries keep the upper half at zero
  typedef struct packed {
    value_type_e vtype;
    logic [63:0] value;
  } stack_entry_t;

endpackage
